// File: tcb_riscv_mem_sys.f
hdl/tcb_pkg.sv
hdl/tcb_riscv2memory.sv
hdl/tcb_mem.sv
hdl/tcb_load_ext.sv
hdl/tcb_riscv_mem_sys.sv
verification/tcb_clk_gen.sv
verification/tcb_riscv_mem_sys_chk.sv
verification/tcb_riscv_mem_sys_tb.sv

// File: run.sh
#!/bin/sh
# build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
  --top-module tcb_riscv_mem_sys_tb \
  -f tcb_riscv_mem_sys.f \
  -o tb_sim

./obj_dir/tb_sim 2>&1 | tee sim.log

# verdict from the log
if grep -q "Testbench passed" sim.log; then
  echo "simulation result: PASS"
  exit 0
else
  echo "simulation result: FAIL"
  exit 1
fi

// File: verification/tcb_riscv_mem_sys_tb.sv
// load/store memory subsystem testbench
`default_nettype none
`timescale 1ns/100ps

module tcb_riscv_mem_sys_tb;

  localparam int unsigned AW   = 10;
  localparam int unsigned DEP  = 2**(AW-2);
  // cycles a request may wait for rdy
  localparam int unsigned TMO  = 20;
  localparam int unsigned NRND = 3000;

  // expected response, rdt ignored for writes
  typedef struct packed {
    logic        chk_rdt;
    logic [31:0] rdt;
    logic        sts;
  } exp_t;

  logic                  sub;
  logic                  arst_n;
  logic                  sub_vld;
  tcb_pkg::tcb_rsc_req_t sub_req;
  logic                  sub_rdy;
  tcb_pkg::tcb_rsp_t     sub_rsp;
  logic                  mal;

  // reference memory as bytes
  logic [7:0]  mdl [2**AW];
  // responses due on the next cycle
  exp_t        exp_q [$];

  tcb_clk_gen clk0 (.sub (sub), .arst_n (arst_n));

  tcb_riscv_mem_sys #(.AW (AW)) dut0 (
    .sub (sub), .arst_n (arst_n), .sub_vld (sub_vld), .sub_req (sub_req),
    .sub_rdy (sub_rdy), .sub_rsp (sub_rsp), .mal (mal)
  );

  //////////////////////////////
  // reporting
  //////////////////////////////

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("[FAIL] %0t ns %s got %h expected %h", $time, name, got, exp);
      $display("Testbench failed");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic abort_run(input string why);
    $display("%0t ns run stopped: %s", $time, why);
    $display("Testbench failed");
    $fatal(1, "timeout");
  endtask

  //////////////////////////////
  // reference model
  //////////////////////////////

  // word fill, every address gets its own value
  function automatic logic [31:0] fill_word(input int unsigned w);
    return (w * 32'h9e37_79b1) ^ (w << 20) ^ 32'h5a3c_0f81;
  endfunction

  function automatic logic is_mal(input tcb_pkg::tcb_rsc_req_t r);
    return (32'(r.adr[1:0]) % (1 << r.siz)) != 0;
  endfunction

  // accepted transfer, update bytes and queue the response
  task automatic model_accept(input tcb_pkg::tcb_rsc_req_t r);
    exp_t        e;
    int unsigned n;
    int unsigned a;
    int unsigned idx;
    logic [31:0] bas;
    logic [31:0] val;
    n   = 1 << r.siz;
    a   = 32'(r.adr[1:0]);
    bas = 32'({r.adr[AW-1:2], 2'b00});
    val = '0;
    e   = '0;
    if (is_mal(r)) begin
      // error status, zero data, memory untouched
      e.sts     = 1'b1;
      e.chk_rdt = 1'b1;
    end else if (r.wen) begin
      // lane a+k gets byte k, or n-1-k for big endian
      for (int k = 0; k < n; k++) begin
        idx = r.ndn ? n - 1 - k : k;
        mdl[AW'(bas + a + k)] = r.wdt[8*idx +: 8];
      end
    end else begin
      for (int j = 0; j < n; j++) begin
        idx = r.ndn ? n - 1 - j : j;
        val[8*j +: 8] = mdl[AW'(bas + a + idx)];
      end
      // sign copies or zeros above byte n-1
      for (int j = n; j < 4; j++) begin
        val[8*j +: 8] = r.uns ? 8'h00 : {8{val[8*n-1]}};
      end
      e.chk_rdt = 1'b1;
      e.rdt     = val;
    end
    exp_q.push_back(e);
  endtask

  //////////////////////////////
  // stimulus
  //////////////////////////////

  function automatic tcb_pkg::tcb_rsc_req_t build_req(
    input logic wen, input logic ndn, input logic uns, input int unsigned siz,
    input logic [31:0] adr, input logic [31:0] wdt
  );
    return '{wen: wen, ndn: ndn, uns: uns, siz: tcb_pkg::tcb_siz_t'(2'(siz)),
             adr: adr, wdt: wdt};
  endfunction

  // mostly aligned, read heavy
  function automatic tcb_pkg::tcb_rsc_req_t random_req(input int unsigned wpct);
    tcb_pkg::tcb_rsc_req_t r;
    logic [1:0]            s;
    s = 2'($urandom_range(0, 2));
    r = build_req($urandom_range(0, 99) < wpct, 1'($urandom), 1'($urandom), s,
                  $urandom, $urandom);
    if ($urandom_range(0, 3) != 0) begin
      r.adr[1:0] = r.adr[1:0] & ~2'((1 << s) - 1);
    end else if (s != 0) begin
      r.adr[0] = 1'b1;
    end
    return r;
  endfunction

  // one request or idle, held until accepted
  task automatic drive_cycle(input logic vld, input tcb_pkg::tcb_rsc_req_t r);
    int unsigned tries;
    exp_t        e;
    tries = 0;
    @(posedge sub);
    sub_vld <= vld;
    sub_req <= r;
    forever begin
      @(negedge sub);
      // response of the previous transfer
      if (exp_q.size() > 0) begin
        e = exp_q.pop_front();
        check_val("sub_rsp.sts", 32'(sub_rsp.sts), 32'(e.sts));
        if (e.chk_rdt) begin
          check_val("sub_rsp.rdt", sub_rsp.rdt, e.rdt);
        end
      end
      if (!sub_vld) break;
      check_val("mal", 32'(mal), 32'(is_mal(r)));
      // misaligned requests complete locally, never stalled
      if (is_mal(r)) begin
        check_val("sub_rdy", 32'(sub_rdy), 32'd1);
      end
      if (sub_rdy) begin
        model_accept(r);
        break;
      end
      tries++;
      if (tries >= TMO) abort_run("sub_rdy stayed low");
      @(posedge sub);
    end
  endtask

  initial begin
    int unsigned tries;
    logic [31:0] adr;
    sub_vld <= 1'b0;
    sub_req <= '0;
    tries   = 0;
    void'($urandom(62292));
    while (arst_n !== 1'b1) begin
      @(posedge sub);
      tries++;
      if (tries >= TMO) abort_run("reset never released");
    end
    // known contents everywhere
    for (int w = 0; w < DEP; w++) begin
      drive_cycle(1'b1, build_req(1'b1, 1'b0, 1'b0, 2, 32'(w * 4), fill_word(w)));
    end
    // le store then zero extended load, each size
    for (int s = 0; s < 3; s++) begin
      adr = $urandom & ~32'((1 << s) - 1);
      drive_cycle(1'b1, build_req(1'b1, 1'b0, 1'b0, s, adr, $urandom));
      drive_cycle(1'b1, build_req(1'b0, 1'b0, 1'b1, s, adr, '0));
    end
    // be word store, le word load sees bytes reversed
    drive_cycle(1'b1, build_req(1'b1, 1'b1, 1'b0, 2, 32'h40, 32'h1122_3344));
    drive_cycle(1'b1, build_req(1'b0, 1'b0, 1'b0, 2, 32'h40, '0));
    // negative byte and half, signed loads
    drive_cycle(1'b1, build_req(1'b1, 1'b0, 1'b0, 0, 32'h81, 32'h0000_0080));
    drive_cycle(1'b1, build_req(1'b0, 1'b0, 1'b0, 0, 32'h81, '0));
    drive_cycle(1'b1, build_req(1'b1, 1'b0, 1'b0, 1, 32'h82, 32'h0000_8001));
    drive_cycle(1'b1, build_req(1'b0, 1'b0, 1'b0, 1, 32'h82, '0));
    drive_cycle(1'b1, build_req(1'b0, 1'b1, 1'b0, 1, 32'h82, '0));
    // misaligned store must not land
    drive_cycle(1'b1, build_req(1'b1, 1'b0, 1'b0, 2, 32'h102, 32'hdead_beef));
    drive_cycle(1'b1, build_req(1'b0, 1'b0, 1'b0, 2, 32'h100, '0));
    drive_cycle(1'b1, build_req(1'b0, 1'b0, 1'b1, 1, 32'h103, '0));
    // random mix, mostly back to back
    for (int i = 0; i < NRND; i++) begin
      if ($urandom_range(0, 4) == 0) begin
        drive_cycle(1'b0, '0);
      end else begin
        drive_cycle(1'b1, random_req(30));
      end
    end
    // last response
    drive_cycle(1'b0, '0);
    $display("Testbench passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: verification/tcb_riscv_mem_sys_chk.sv
// converter handshake assertions
`default_nettype none
`timescale 1ns/100ps

module tcb_riscv_mem_sys_chk (
  input logic                  sub,
  input logic                  arst_n,
  input logic                  sub_rdy,
  input logic                  mal,
  input logic                  man_vld,
  input logic                  man_rdy,
  input tcb_pkg::tcb_mem_req_t man_req
);

  //////////////////////////////
  // misalignment
  //////////////////////////////

  // a misaligned request stays off the memory bus
  mal_blocks_vld: assert property (@(posedge sub) disable iff (!arst_n) mal |-> !man_vld)
    else $error("man_vld high together with mal");

  //////////////////////////////
  // handshake
  //////////////////////////////

  // stalled request held until accepted
  req_stable: assert property (@(posedge sub) disable iff (!arst_n)
    (man_vld && !man_rdy) |=> $stable(man_req))
    else $error("man_req changed while stalled");

  // both sides quiet in reset
  rst_quiet: assert property (@(posedge sub) !arst_n |-> (!sub_rdy && !man_vld))
    else $error("sub_rdy or man_vld high during reset");

endmodule

// attach to every converter instance
bind tcb_riscv2memory tcb_riscv_mem_sys_chk chk0 (
  .sub     (sub),
  .arst_n  (arst_n),
  .sub_rdy (sub_rdy),
  .mal     (mal),
  .man_vld (man_vld),
  .man_rdy (man_rdy),
  .man_req (man_req)
);

`default_nettype wire

// File: verification/tcb_clk_gen.sv
// testbench clock and reset
`default_nettype none
`timescale 1ns/100ps

module tcb_clk_gen #(
  parameter int unsigned PERIOD  = 8,
  parameter int unsigned RST_CYC = 2
) (
  output logic sub,
  output logic arst_n
);

  // free running clock
  initial begin
    sub = 1'b0;
    forever #(PERIOD / 2) sub = ~sub;
  end

  // reset low for the first rising edges
  initial begin
    arst_n = 1'b0;
    repeat (RST_CYC) @(posedge sub);
    arst_n <= 1'b1;
  end

endmodule

`default_nettype wire

// File: hdl/tcb_riscv_mem_sys.sv
// risc-v load/store memory subsystem
`default_nettype none
`timescale 1ns/100ps

module tcb_riscv_mem_sys #(
  // used address bits, 10 gives 1 KiB
  parameter int unsigned AW = 10
) (
  input  logic                  sub,
  input  logic                  arst_n,
  // processor side bus
  input  logic                  sub_vld,
  input  tcb_pkg::tcb_rsc_req_t sub_req,
  output logic                  sub_rdy,
  output tcb_pkg::tcb_rsp_t     sub_rsp,
  // misaligned access
  output logic                  mal
);

  // memory side bus
  logic                  man_vld;
  logic                  man_rdy;
  tcb_pkg::tcb_mem_req_t man_req;
  tcb_pkg::tcb_rsp_t     man_rsp;
  // realigned response before extension
  tcb_pkg::tcb_rsp_t     cnv_rsp;
  // processor side transfer strobe
  logic                  xfr;

  assign xfr = sub_vld & sub_rdy;

  //////////////////////////////
  // lane conversion
  //////////////////////////////

  tcb_riscv2memory #(
    .AW (AW)
  ) cnv0 (
    .sub     (sub),
    .arst_n  (arst_n),
    .sub_vld (sub_vld),
    .sub_req (sub_req),
    .sub_rdy (sub_rdy),
    .sub_rsp (cnv_rsp),
    .mal     (mal),
    .man_vld (man_vld),
    .man_req (man_req),
    .man_rdy (man_rdy),
    .man_rsp (man_rsp)
  );

  //////////////////////////////
  // memory and extension
  //////////////////////////////

  tcb_mem #(
    .AW (AW)
  ) mem0 (
    .sub    (sub),
    .arst_n (arst_n),
    .vld    (man_vld),
    .req    (man_req),
    .rdy    (man_rdy),
    .rsp    (man_rsp)
  );

  // extension uses the attributes of the accepted request
  tcb_load_ext ext0 (
    .sub     (sub),
    .arst_n  (arst_n),
    .xfr     (xfr),
    .siz     (sub_req.siz),
    .uns     (sub_req.uns),
    .wen     (sub_req.wen),
    .rsp_in  (cnv_rsp),
    .rsp_out (sub_rsp)
  );

endmodule

`default_nettype wire

// File: hdl/tcb_load_ext.sv
// load data sign and zero extension
`default_nettype none
`timescale 1ns/100ps

module tcb_load_ext (
  input  logic              sub,
  input  logic              arst_n,
  // processor side transfer and its attributes
  input  logic              xfr,
  input  tcb_pkg::tcb_siz_t siz,
  input  logic              uns,
  input  logic              wen,
  // response from the converter
  input  tcb_pkg::tcb_rsp_t rsp_in,
  // extended response
  output tcb_pkg::tcb_rsp_t rsp_out
);

  // attributes of the transfer now in response
  tcb_pkg::tcb_siz_t siz_q;
  logic              uns_q;
  logic              wen_q;
  // fill bits for byte and half loads
  logic              fil_b;
  logic              fil_h;

  //////////////////////////////
  // request side capture
  //////////////////////////////

  always_ff @(posedge sub or negedge arst_n) begin
    if (!arst_n) begin
      siz_q <= tcb_pkg::SIZ_W;
      uns_q <= 1'b0;
      wen_q <= 1'b0;
    end else if (xfr) begin
      siz_q <= siz;
      uns_q <= uns;
      wen_q <= wen;
    end
  end

  //////////////////////////////
  // extension
  //////////////////////////////

  // top bit of the last loaded byte, or zero
  assign fil_b = ~uns_q & rsp_in.rdt[7];
  assign fil_h = ~uns_q & rsp_in.rdt[15];

  always_comb begin
    rsp_out = rsp_in;
    // writes and errors go through as they are
    if (!wen_q && (rsp_in.sts == tcb_pkg::STS_OK)) begin
      case (siz_q)
        tcb_pkg::SIZ_B: rsp_out.rdt[31:8] = {24{fil_b}};
        tcb_pkg::SIZ_H: rsp_out.rdt[31:16] = {16{fil_h}};
        // full word needs nothing
        default: rsp_out.rdt = rsp_in.rdt;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: hdl/tcb_mem.sv
// byte enabled single port memory
`default_nettype none
`timescale 1ns/100ps

module tcb_mem #(
  // used address bits
  parameter int unsigned AW = 10
) (
  input  logic                  sub,
  input  logic                  arst_n,
  // request side
  input  logic                  vld,
  input  tcb_pkg::tcb_mem_req_t req,
  output logic                  rdy,
  // response side
  output tcb_pkg::tcb_rsp_t     rsp
);

  localparam int unsigned BEN = tcb_pkg::BEN;
  // words in the array
  localparam int unsigned DEP = 2**(AW-2);

  //////////////////////////////
  // storage
  //////////////////////////////

  // word array, lane i is byte address offset i
  logic [BEN-1:0][7:0] mem [DEP];

  // word index from the byte address
  logic [AW-3:0]       wad;
  // write data split into lanes
  logic [BEN-1:0][7:0] wdt_b;
  // transfer strobe
  logic                xfr;
  // registered read word
  logic [BEN-1:0][7:0] rdt_q;

  assign wad   = req.adr[AW-1:2];
  assign wdt_b = req.wdt;
  assign xfr   = vld & rdy;

  //////////////////////////////
  // handshake
  //////////////////////////////

  // never stalls once out of reset
  always_ff @(posedge sub or negedge arst_n) begin
    if (!arst_n) begin
      rdy <= 1'b0;
    end else begin
      rdy <= 1'b1;
    end
  end

  //////////////////////////////
  // write and read
  //////////////////////////////

  // write only the enabled lanes
  always_ff @(posedge sub) begin
    if (xfr && req.wen) begin
      for (int i = 0; i < BEN; i++) begin
        if (req.ben[i]) begin
          mem[wad][i] <= wdt_b[i];
        end
      end
    end
  end

  // full word read, lanes sorted out upstream
  always_ff @(posedge sub) begin
    if (xfr && !req.wen) begin
      rdt_q <= mem[wad];
    end
  end

  // response on the cycle after the transfer
  // status is always ok here
  assign rsp = '{
    rdt: rdt_q,
    sts: tcb_pkg::STS_OK
  };

endmodule

`default_nettype wire

// File: hdl/tcb_riscv2memory.sv
// risc-v to memory lane converter
`default_nettype none
`timescale 1ns/100ps

module tcb_riscv2memory #(
  // used address bits
  parameter int unsigned AW = 10
) (
  input  logic                  sub,
  input  logic                  arst_n,
  // processor side
  input  logic                  sub_vld,
  input  tcb_pkg::tcb_rsc_req_t sub_req,
  output logic                  sub_rdy,
  output tcb_pkg::tcb_rsp_t     sub_rsp,
  // misaligned access
  output logic                  mal,
  // memory side
  output logic                  man_vld,
  output tcb_pkg::tcb_mem_req_t man_req,
  input  logic                  man_rdy,
  input  tcb_pkg::tcb_rsp_t     man_rsp
);

  localparam int unsigned BEN = tcb_pkg::BEN;

  // out of reset flag
  logic                run;
  // misalignment of current request
  logic                mis;
  // byte offset inside the word
  logic [1:0]          ofs;
  // size in bytes minus one
  logic [1:0]          nm1;
  // byte enables
  logic [BEN-1:0]      ben;
  // data as byte arrays
  logic [BEN-1:0][7:0] req_byt;
  logic [BEN-1:0][7:0] man_lan;
  logic [BEN-1:0][7:0] rsp_lan;
  logic [BEN-1:0][7:0] rsp_byt;
  // transfer byte index seen from each lane
  logic [1:0]          lane_k [BEN];
  // write mux select per lane
  logic [1:0]          wsel   [BEN];
  // read mux select per output byte
  logic [1:0]          rsel   [BEN];
  logic [1:0]          rsel_q [BEN];
  // valid bytes of the load result
  logic [BEN-1:0]      rmsk;
  logic [BEN-1:0]      rmsk_q;
  // previous transfer was misaligned
  logic                err_q;

  //////////////////////////////
  // alignment check
  //////////////////////////////

  assign ofs = sub_req.adr[1:0];

  always_comb begin
    case (sub_req.siz)
      tcb_pkg::SIZ_B: begin
        mis = 1'b0;
        nm1 = 2'd0;
      end
      tcb_pkg::SIZ_H: begin
        mis = sub_req.adr[0];
        nm1 = 2'd1;
      end
      tcb_pkg::SIZ_W: begin
        mis = |sub_req.adr[1:0];
        nm1 = 2'd3;
      end
      default: begin
        // illegal size code, kept off the memory
        mis = 1'b1;
        nm1 = 2'd3;
      end
    endcase
  end

  assign mal = sub_vld & mis;

  // misaligned requests never reach memory
  assign man_vld = sub_vld & ~mis & run;
  // errors complete locally, aligned ones follow memory
  assign sub_rdy = mis ? run : man_rdy;

  //////////////////////////////
  // request lanes
  //////////////////////////////

  assign req_byt = sub_req.wdt;

  always_comb begin
    for (int i = 0; i < BEN; i++) begin
      // which transfer byte lands on lane i, little endian
      lane_k[i] = 2'(i) - ofs;
      // lanes ofs .. ofs+n-1 are active
      ben[i]    = (lane_k[i] <= nm1);
      // big endian mirrors the order inside the access
      wsel[i]   = sub_req.ndn ? (nm1 - lane_k[i]) : lane_k[i];
      man_lan[i] = req_byt[wsel[i]];
      // inverse map, output byte i comes from this lane
      rsel[i]   = sub_req.ndn ? (ofs + nm1 - 2'(i)) : (ofs + 2'(i));
      // bytes above the access size are cleared
      rmsk[i]   = (2'(i) <= nm1);
    end
  end

  // word aligned address, unused high bits zero
  assign man_req = '{
    wen: sub_req.wen,
    ben: ben,
    adr: 32'({sub_req.adr[AW-1:2], 2'b00}),
    wdt: man_lan
  };

  //////////////////////////////
  // response lanes
  //////////////////////////////

  // read select and error follow the transfer by one cycle
  always_ff @(posedge sub or negedge arst_n) begin
    if (!arst_n) begin
      run    <= 1'b0;
      err_q  <= 1'b0;
      rmsk_q <= '0;
      rsel_q <= '{default: 2'd0};
    end else begin
      run    <= 1'b1;
      err_q  <= mal & sub_rdy;
      rmsk_q <= rmsk;
      rsel_q <= rsel;
    end
  end

  assign rsp_lan = man_rsp.rdt;

  always_comb begin
    for (int i = 0; i < BEN; i++) begin
      rsp_byt[i] = rmsk_q[i] ? rsp_lan[rsel_q[i]] : 8'h00;
    end
  end

  // error response carries no data
  always_comb begin
    if (err_q) begin
      sub_rsp.rdt = '0;
      sub_rsp.sts = tcb_pkg::STS_MAL;
    end else begin
      sub_rsp.rdt = rsp_byt;
      sub_rsp.sts = man_rsp.sts;
    end
  end

endmodule

`default_nettype wire

// File: hdl/tcb_pkg.sv
// tightly coupled bus types
`default_nettype none

package tcb_pkg;

  //////////////////////////////
  // bus geometry
  //////////////////////////////

  // byte lanes on the 32-bit data bus
  localparam int unsigned BEN = 4;

  //////////////////////////////
  // size and status codes
  //////////////////////////////

  // access size as log2 of bytes
  // code 3 would be 8 bytes, not supported here
  typedef enum logic [1:0] {
    SIZ_B = 2'd0,
    SIZ_H = 2'd1,
    SIZ_W = 2'd2
  } tcb_siz_t;

  // response status
  typedef enum logic {
    STS_OK  = 1'b0,
    STS_MAL = 1'b1
  } tcb_sts_t;

  //////////////////////////////
  // request and response
  //////////////////////////////

  // processor side request, risc-v style
  typedef struct packed {
    // write enable
    logic        wen;
    // 1 means big endian
    logic        ndn;
    // unsigned load
    logic        uns;
    // access size
    tcb_siz_t    siz;
    // byte address, low bits pick the lane
    logic [31:0] adr;
    // store value in the low bytes
    logic [31:0] wdt;
  } tcb_rsc_req_t;

  // memory side request, byte lanes
  typedef struct packed {
    // write enable
    logic           wen;
    // byte enables per lane
    logic [BEN-1:0] ben;
    // word aligned address
    logic [31:0]    adr;
    // lane ordered write data
    logic [31:0]    wdt;
  } tcb_mem_req_t;

  // response, same shape on both sides
  typedef struct packed {
    // read data
    logic [31:0] rdt;
    // status
    tcb_sts_t    sts;
  } tcb_rsp_t;

endpackage

`default_nettype wire
